// File: conv_reducer_top.f
verilog/pe_array_pkg.sv
verilog/apb_pkg.sv
verilog/apb_regfile.sv
verilog/row_multiplier.sv
verilog/psum_fifo.sv
verilog/reducer.sv
verilog/conv_reducer_top.sv
testbench/tb_clock_gen.sv
testbench/tb_conv_reducer.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, then run it
# the exit status is the simulator's own, nonzero after any $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_conv_reducer \
    -f conv_reducer_top.f \
    --Mdir obj_dir -o tb_conv_reducer
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_conv_reducer
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation ended with status $sim_status"
    exit $sim_status
fi

echo "simulation ended cleanly"
exit 0

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    // synchronous reset, high for the first 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: testbench/tb_conv_reducer.sv
module tb_conv_reducer;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int apb_timeout    = 50;    // cycles held in access phase
    localparam int result_timeout = 100;   // status polls
    localparam int reset_timeout  = 20;

    logic                       clk;
    logic                       reset;
    apb_pkg::apb_req_t          apb_req;
    apb_pkg::apb_resp_t         apb_resp;
    logic [31:0]                lfsr_state;
    pe_array_pkg::operand_vec_t cur_w;
    pe_array_pkg::operand_vec_t cur_a;
    pe_array_pkg::lane_vec_t    cur_i;
    pe_array_pkg::opsum_u       expect_opsum;    // word the monitor checks reads against
    pe_array_pkg::opsum_u       pending_q[$];    // jobs in flight in start order
    logic [4:0]                 mon_lane;
    int                         lanes_read;
    int                         lanes_checked;

    tb_clock_gen u_clk_gen (.clk, .reset);

    conv_reducer_top UUT (.clk, .reset, .apb_req, .apb_resp);

    // ------------------------------
    // stimulus source and reference model
    // ------------------------------
    // galois lfsr for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic pe_array_pkg::opsum_u reduce_ref(
        input pe_array_pkg::operand_vec_t w,
        input pe_array_pkg::operand_vec_t a,
        input pe_array_pkg::lane_vec_t    ip,
        input pe_array_pkg::reduce_mode_t mode
    );
        int                   prod [pe_array_pkg::row_num];
        int                   acc;
        pe_array_pkg::opsum_u r;
        r = '0;
        for (int i = 0; i < pe_array_pkg::row_num; i++)
            prod[i] = int'(w[i]) * int'(a[i]);     // exact product before the 16-bit wrap
        if (mode == pe_array_pkg::mode_pw) begin
            for (int i = 0; i < pe_array_pkg::row_num; i++) begin
                acc = prod[i] + int'(ip[i]);
                r.pw[i] = acc[15:0];
            end
        end else begin
            // group sum lands in the group's first lane and lanes 30 and 31 stay zero
            for (int i = 0; i < 3 * pe_array_pkg::dw_group_num; i += 3) begin
                acc = prod[i] + prod[i+1] + prod[i+2] + int'(ip[i]);
                r.pw[i] = acc[15:0];
            end
        end
        return r;
    endfunction

    // ------------------------------
    // checks
    // ------------------------------
    task automatic fail_run();
        $display("tests failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic compare_lane(input string name, input pe_array_pkg::lane_t exp,
                                input pe_array_pkg::lane_t act);
        if (act !== exp) begin
            $display("error %s: expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic compare_status(input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("error status: expected %h actual %h", exp, act);
            fail_run();
        end
    endtask

    task automatic compare_slverr(input logic [11:0] addr, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error pslverr at %h: expected %h actual %h", addr, exp, act);
            fail_run();
        end
    endtask

    // passive monitor checks every completed opsum read against expect_opsum
    always @(negedge clk) begin
        if (apb_req.psel && apb_req.penable && !apb_req.pwrite && apb_resp.pready
            && apb_req.paddr[11:7] == apb_pkg::addr_opsum_base[11:7]) begin
            mon_lane = apb_req.paddr[6:2];
            compare_lane($sformatf("opsum[%0d]", mon_lane), expect_opsum.pw[mon_lane],
                         apb_resp.prdata[15:0]);
            if (apb_resp.prdata[31:16] !== {16{apb_resp.prdata[15]}}) begin
                $display("opsum lane %0d was not sign extended to 32 bits", mon_lane);
                fail_run();
            end
            lanes_checked++;
        end
    end

    // ------------------------------
    // apb driver
    // ------------------------------
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        int   waited;
        logic is_start;
        is_start = write && addr == apb_pkg::addr_ctrl && wdata[0];
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;            // access phase
        waited = 0;
        @(negedge clk);
        while (!apb_resp.pready) begin      // start writes stretch here
            if (waited == apb_timeout) begin
                $display("apb transfer to %h never completed", addr);
                fail_run();
            end
            waited++;
            @(negedge clk);
        end
        // only a start write may add wait states
        if (waited != 0 && !is_start) begin
            $display("apb transfer to %h was held %0d cycles past its access phase",
                     addr, waited);
            fail_run();
        end
        rdata  = apb_resp.prdata;
        slverr = apb_resp.pslverr;
        @(posedge clk);                     // completing edge
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] d;
        logic        e;
        apb_access(1'b1, addr, data, d, e);
        compare_slverr(addr, 1'b0, e);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic e);
        apb_access(1'b0, addr, 32'd0, data, e);
    endtask

    task automatic read_status(output logic [3:0] st);
        logic [31:0] d;
        logic        e;
        apb_read(apb_pkg::addr_status, d, e);
        compare_slverr(apb_pkg::addr_status, 1'b0, e);
        st = d[3:0];
    endtask

    // ------------------------------
    // job level tasks
    // ------------------------------
    task automatic load_operands(input pe_array_pkg::operand_vec_t w,
                                 input pe_array_pkg::operand_vec_t a,
                                 input pe_array_pkg::lane_vec_t ip);
        for (int i = 0; i < pe_array_pkg::row_num; i++) begin
            apb_write(apb_pkg::addr_weight_base + 12'(4 * i), {24'd0, w[i]});
            apb_write(apb_pkg::addr_act_base + 12'(4 * i), {24'd0, a[i]});
            apb_write(apb_pkg::addr_ipsum_base + 12'(4 * i), {16'd0, ip[i]});
        end
        cur_w = w;
        cur_a = a;
        cur_i = ip;
    endtask

    task automatic load_random();
        pe_array_pkg::operand_vec_t w;
        pe_array_pkg::operand_vec_t a;
        pe_array_pkg::lane_vec_t    ip;
        logic [31:0]                r;
        for (int i = 0; i < pe_array_pkg::row_num; i++) begin
            r = take_bits(8);
            w[i] = r[7:0];
            r = take_bits(8);
            a[i] = r[7:0];
            r = take_bits(16);
            ip[i] = r[15:0];
        end
        load_operands(w, a, ip);
    endtask

    task automatic start_job(input pe_array_pkg::reduce_mode_t mode);
        logic [3:0] st;
        apb_write(apb_pkg::addr_ctrl, {30'd0, mode, 1'b1});
        pending_q.push_back(reduce_ref(cur_w, cur_a, cur_i, mode));
        read_status(st);
        if (st[3:1] > 3'd4) begin
            $display("fifo count %0d is above the fifo depth", st[3:1]);
            fail_run();
        end
    endtask

    task automatic read_opsum_lanes();
        logic [31:0] d;
        logic        e;
        for (int i = 0; i < pe_array_pkg::row_num; i++) begin
            apb_read(apb_pkg::addr_opsum_base + 12'(4 * i), d, e);
            compare_slverr(apb_pkg::addr_opsum_base + 12'(4 * i), 1'b0, e);
            lanes_read++;
        end
    endtask

    // waits for result_valid, checks the oldest job, then acks it
    task automatic check_result();
        logic [3:0] st;
        int         polls;
        polls = 0;
        read_status(st);
        while (!st[0]) begin
            if (polls == result_timeout) begin
                $display("result_valid never rose");
                fail_run();
            end
            polls++;
            read_status(st);
        end
        if (pending_q.size() == 0) begin
            $display("a result appeared with no job in flight");
            fail_run();
        end
        expect_opsum = pending_q.pop_front();
        read_opsum_lanes();
        apb_write(apb_pkg::addr_ack, 32'd0);
    endtask

    task automatic bad_access(input logic write, input logic [11:0] addr);
        logic [31:0] d;
        logic        e;
        apb_access(write, addr, 32'h0000_7fff, d, e);
        compare_slverr(addr, 1'b1, e);
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [31:0] r;
        logic [3:0]  st;
        int          waited;
        apb_req       = '0;
        lfsr_state    = 32'haad26cbf;
        cur_w         = '0;
        cur_a         = '0;
        cur_i         = '0;
        expect_opsum  = '0;
        lanes_read    = 0;
        lanes_checked = 0;
        waited        = 0;
        while (reset !== 1'b0) begin
            if (waited == reset_timeout) begin
                $display("reset was never released");
                fail_run();
            end
            waited++;
            @(posedge clk);
        end

        read_status(st);                    // clean state after reset
        compare_status(4'h0, st);
        read_opsum_lanes();

        for (int j = 0; j < 3; j++) begin   // pointwise
            load_random();
            start_job(pe_array_pkg::mode_pw);
            check_result();
        end
        for (int j = 0; j < 3; j++) begin   // depthwise
            load_random();
            start_job(pe_array_pkg::mode_dw);
            check_result();
        end

        // six in flight with no ack until all are started
        for (int j = 0; j < 6; j++) begin
            load_random();
            r = take_bits(1);
            start_job(pe_array_pkg::reduce_mode_t'(r[0]));
        end
        read_status(st);                    // reducer, full fifo and multiplier all held
        compare_status(4'h9, st);
        for (int j = 0; j < 6; j++)
            check_result();

        // illegal accesses leave the held result and the banks alone
        bad_access(1'b1, apb_pkg::addr_opsum_base + 12'h004);
        bad_access(1'b1, apb_pkg::addr_status);
        bad_access(1'b1, 12'h010);
        bad_access(1'b0, 12'h0fc);
        bad_access(1'b1, apb_pkg::addr_weight_base + 12'h002);   // misaligned
        read_opsum_lanes();
        read_status(st);
        compare_status(4'h0, st);
        start_job(pe_array_pkg::mode_pw);   // same banks as the last job
        check_result();

        // extreme operands give products of 0x4000 against ipsum 0x7fff
        load_operands({32{8'h80}}, {32{8'h80}}, {32{16'h7fff}});
        start_job(pe_array_pkg::mode_pw);
        check_result();
        read_status(st);                    // ack dropped result_valid
        compare_status(4'h0, st);
        start_job(pe_array_pkg::mode_dw);
        check_result();
        read_status(st);
        compare_status(4'h0, st);

        if (lanes_checked != lanes_read || pending_q.size() != 0) begin
            $display("monitor compared %0d of %0d opsum reads, %0d jobs left",
                     lanes_checked, lanes_read, pending_q.size());
            fail_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: verilog/apb_pkg.sv
package apb_pkg;

    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [apb_addr_w-1:0] paddr;
        logic [apb_data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                  pready;
        logic [apb_data_w-1:0] prdata;
        logic                  pslverr;
    } apb_resp_t;

    // ------------------------------
    // byte address map
    // ------------------------------
    localparam logic [apb_addr_w-1:0] addr_ctrl        = 12'h000;  // b0 start, b1 mode (1 = pw)
    localparam logic [apb_addr_w-1:0] addr_status      = 12'h004;  // b0 result_valid, b3:1 count
    localparam logic [apb_addr_w-1:0] addr_ack         = 12'h008;  // write drops result_valid
    localparam logic [apb_addr_w-1:0] addr_weight_base = 12'h100;
    localparam logic [apb_addr_w-1:0] addr_act_base    = 12'h200;
    localparam logic [apb_addr_w-1:0] addr_ipsum_base  = 12'h300;
    localparam logic [apb_addr_w-1:0] addr_opsum_base  = 12'h400;  // read only

    // a lane bank spans 32 words, so paddr above this bit picks the bank
    localparam int bank_lsb = 7;

endpackage

// File: verilog/apb_regfile.sv
module apb_regfile (
    input  logic                       clk,
    input  logic                       reset,
    input  apb_pkg::apb_req_t          apb_req,
    output apb_pkg::apb_resp_t         apb_resp,
    output logic                       start_valid,
    input  logic                       start_ready,
    output pe_array_pkg::operand_vec_t weights,
    output pe_array_pkg::operand_vec_t acts,
    output pe_array_pkg::lane_vec_t    ipsums,
    output pe_array_pkg::reduce_mode_t mode,
    input  logic [2:0]                 fifo_count,
    input  logic                       result_valid,
    input  pe_array_pkg::opsum_u       result,
    output logic                       result_clear
);

    localparam int hi = apb_pkg::apb_addr_w - 1;
    localparam int lo = apb_pkg::bank_lsb;

    logic                                access;
    logic                                is_start;
    logic                                done;
    logic                                wr_en;
    logic                                err;
    logic                                hit_ctrl, hit_status, hit_ack;
    logic                                hit_w, hit_a, hit_i, hit_o;
    logic [pe_array_pkg::lane_idx_w-1:0] lane_idx;
    pe_array_pkg::reduce_mode_t          mode_q;
    pe_array_pkg::lane_t                 rd_lane;

    // ------------------------------
    // address decode
    // ------------------------------
    assign access   = apb_req.psel & apb_req.penable;   // access phase
    assign lane_idx = apb_req.paddr[lo-1:2];

    always_comb begin
        hit_ctrl   = apb_req.paddr == apb_pkg::addr_ctrl;
        hit_status = apb_req.paddr == apb_pkg::addr_status;
        hit_ack    = apb_req.paddr == apb_pkg::addr_ack;
        // bank hits need word alignment too
        hit_w = apb_req.paddr[hi:lo] == apb_pkg::addr_weight_base[hi:lo]
                && apb_req.paddr[1:0] == 2'b00;
        hit_a = apb_req.paddr[hi:lo] == apb_pkg::addr_act_base[hi:lo]
                && apb_req.paddr[1:0] == 2'b00;
        hit_i = apb_req.paddr[hi:lo] == apb_pkg::addr_ipsum_base[hi:lo]
                && apb_req.paddr[1:0] == 2'b00;
        hit_o = apb_req.paddr[hi:lo] == apb_pkg::addr_opsum_base[hi:lo]
                && apb_req.paddr[1:0] == 2'b00;
        err = !(hit_ctrl | hit_status | hit_ack | hit_w | hit_a | hit_i | hit_o)
              | (apb_req.pwrite & (hit_status | hit_o));   // read-only targets
    end

    // start write stretches until the multiplier can take it
    assign is_start     = hit_ctrl & apb_req.pwrite & apb_req.pwdata[0];
    assign done         = access & !(is_start & !start_ready);
    assign wr_en        = done & apb_req.pwrite & !err;
    assign start_valid  = wr_en & is_start;     // single pulse, completing cycle
    assign result_clear = wr_en & hit_ack;

    // mode rides along with the start write itself
    assign mode = (access & hit_ctrl & apb_req.pwrite)
                ? pe_array_pkg::reduce_mode_t'(apb_req.pwdata[1]) : mode_q;

    // ------------------------------
    // operand banks and control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            weights <= '0;
            acts    <= '0;
            ipsums  <= '0;
            mode_q  <= pe_array_pkg::mode_dw;
        end else if (wr_en) begin
            if (hit_ctrl) mode_q <= pe_array_pkg::reduce_mode_t'(apb_req.pwdata[1]);
            if (hit_w) weights[lane_idx] <= apb_req.pwdata[7:0];   // low byte only
            if (hit_a) acts[lane_idx]    <= apb_req.pwdata[7:0];
            if (hit_i) ipsums[lane_idx]  <= apb_req.pwdata[15:0];
        end
    end

    // ------------------------------
    // read mux and response
    // ------------------------------
    always_comb begin
        rd_lane = '0;
        if (hit_o)      rd_lane = result.pw[lane_idx];    // mode-blind lane view
        else if (hit_i) rd_lane = ipsums[lane_idx];
        else if (hit_w) rd_lane = 16'(weights[lane_idx]);
        else if (hit_a) rd_lane = 16'(acts[lane_idx]);

        apb_resp.pready  = done | !access;
        apb_resp.pslverr = access & err;
        apb_resp.prdata  = '0;
        if (hit_status)
            apb_resp.prdata = {28'd0, fifo_count, result_valid};
        else if (hit_ctrl)
            apb_resp.prdata = {30'd0, mode_q, 1'b0};      // start bit reads back 0
        else if (hit_o | hit_i | hit_w | hit_a)
            apb_resp.prdata = {{16{rd_lane[15]}}, rd_lane}; // sign extend
    end

endmodule

// File: verilog/conv_reducer_top.sv
module conv_reducer_top (
    input  logic               clk,
    input  logic               reset,
    input  apb_pkg::apb_req_t  apb_req,
    output apb_pkg::apb_resp_t apb_resp
);

    // start path
    logic                       start_valid;
    logic                       start_ready;
    pe_array_pkg::operand_vec_t weights;
    pe_array_pkg::operand_vec_t acts;
    pe_array_pkg::lane_vec_t    ipsums;
    pe_array_pkg::reduce_mode_t mode;

    // job path
    logic                       mul_valid, mul_ready;
    pe_array_pkg::job_t         mul_job;
    logic                       red_valid, red_ready;
    pe_array_pkg::job_t         red_job;
    logic [2:0]                 fifo_count;

    // result path
    logic                       result_valid;
    logic                       result_clear;
    pe_array_pkg::opsum_u       result;

    // ------------------------------
    // host -> producer -> buffer -> consumer
    // ------------------------------
    apb_regfile u_regfile (
        .clk, .reset, .apb_req, .apb_resp,
        .start_valid, .start_ready,
        .weights, .acts, .ipsums, .mode,
        .fifo_count, .result_valid, .result, .result_clear
    );

    row_multiplier u_mult (
        .clk, .reset, .start_valid, .start_ready,
        .weights, .acts, .ipsums, .mode,
        .out_valid (mul_valid),
        .out_ready (mul_ready),
        .out_job   (mul_job)
    );

    psum_fifo u_fifo (
        .clk, .reset,
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .in_job    (mul_job),
        .out_valid (red_valid),
        .out_ready (red_ready),
        .out_job   (red_job),
        .count     (fifo_count)
    );

    reducer u_reducer (
        .clk, .reset,
        .in_valid  (red_valid),
        .in_ready  (red_ready),
        .in_job    (red_job),
        .result_valid, .result, .result_clear
    );

endmodule

// File: verilog/pe_array_pkg.sv
package pe_array_pkg;

    // ------------------------------
    // array geometry
    // ------------------------------
    localparam int row_num      = 32;
    localparam int dw_group_num = 10;               // rows 0..29, three rows each
    localparam int lane_idx_w   = $clog2(row_num);  // lane select from apb offset
    localparam int fifo_depth   = 4;
    localparam int fifo_ptr_w   = $clog2(fifo_depth);

    // ------------------------------
    // lane types
    // ------------------------------
    typedef logic signed [7:0]  operand_t;    // weight or activation
    typedef logic signed [15:0] lane_t;       // product, ipsum or opsum

    typedef lane_t    [row_num-1:0] lane_vec_t;     // 512 bits, lane i at bits i*16
    typedef operand_t [row_num-1:0] operand_vec_t;

    typedef enum logic {
        mode_dw = 1'b0,   // depthwise / conv, groups of three rows
        mode_pw = 1'b1    // pointwise, lane by lane
    } reduce_mode_t;

    // one job as it moves multiplier -> fifo -> reducer
    typedef struct packed {
        lane_vec_t    products;
        lane_vec_t    ipsums;
        reduce_mode_t mode;
    } job_t;

    // sum sits in the low lane so group g lines up with lanes 3g..3g+2
    typedef struct packed {
        lane_t zero_hi;   // lane 3g+2
        lane_t zero_lo;   // lane 3g+1
        lane_t sum;       // lane 3g
    } dw_group_t;

    typedef struct packed {
        lane_t     [1:0]              tail;     // lanes 30 and 31, always zero
        dw_group_t [dw_group_num-1:0] groups;   // 480 bits
    } dw_view_t;

    // same 512-bit opsum word, decoded per lane or per group
    typedef union packed {
        lane_vec_t pw;
        dw_view_t  dw;
    } opsum_u;

endpackage

// File: verilog/psum_fifo.sv
module psum_fifo (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  pe_array_pkg::job_t in_job,
    output logic               out_valid,
    input  logic               out_ready,
    output pe_array_pkg::job_t out_job,
    output logic [2:0]         count
);

    pe_array_pkg::job_t                  mem [pe_array_pkg::fifo_depth];
    logic [pe_array_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [pe_array_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic                                full;
    logic                                push;
    logic                                pop;

    assign full      = count == 3'(pe_array_pkg::fifo_depth);
    assign out_valid = count != 3'd0;     // registered storage, no fall-through
    assign out_job   = mem[rd_ptr];
    assign in_ready  = !full | out_ready; // full but draining still takes one
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_job;
    end

endmodule

// File: verilog/reducer.sv
module reducer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  pe_array_pkg::job_t   in_job,
    output logic                 result_valid,
    output pe_array_pkg::opsum_u result,
    input  logic                 result_clear
);

    pe_array_pkg::opsum_u nxt;
    logic                 pop;

    // ------------------------------
    // pw / dw reduction, wraps at 16 bits
    // ------------------------------
    always_comb begin
        nxt = '0;   // dw pad lanes and tail stay zero
        if (in_job.mode == pe_array_pkg::mode_pw) begin
            for (int i = 0; i < pe_array_pkg::row_num; i++) begin
                nxt.pw[i] = in_job.products[i] + in_job.ipsums[i];
            end
        end else begin
            for (int g = 0; g < pe_array_pkg::dw_group_num; g++) begin
                // three rows plus the first row's ipsum
                nxt.dw.groups[g].sum = in_job.products[3*g]
                                     + in_job.products[3*g+1]
                                     + in_job.products[3*g+2]
                                     + in_job.ipsums[3*g];
            end
        end
    end

    assign in_ready = !result_valid;     // one result held at a time
    assign pop      = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else if (pop) begin
            result_valid <= 1'b1;
            result       <= nxt;
        end else if (result_clear) begin
            result_valid <= 1'b0;        // ack from host, value kept for readback
        end
    end

endmodule

// File: verilog/row_multiplier.sv
module row_multiplier (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_valid,
    output logic                       start_ready,
    input  pe_array_pkg::operand_vec_t weights,
    input  pe_array_pkg::operand_vec_t acts,
    input  pe_array_pkg::lane_vec_t    ipsums,
    input  pe_array_pkg::reduce_mode_t mode,
    output logic                       out_valid,
    input  logic                       out_ready,
    output pe_array_pkg::job_t         out_job
);

    pe_array_pkg::lane_vec_t products;
    logic                    accept;

    // ------------------------------
    // 32 signed 8x8 products
    // ------------------------------
    always_comb begin
        for (int i = 0; i < pe_array_pkg::row_num; i++) begin
            products[i] = $signed(weights[i]) * $signed(acts[i]);  // full 16-bit result
        end
    end

    // free when empty or the fifo takes the held bundle this edge
    assign start_ready = !out_valid | out_ready;
    assign accept      = start_valid & start_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;      // bundle taken, nothing new behind it
        end
    end

    // payload only moves on accept, held otherwise
    always_ff @(posedge clk) begin
        if (accept) begin
            out_job.products <= products;
            out_job.ipsums   <= ipsums;
            out_job.mode     <= mode;
        end
    end

endmodule
